/* bench/csr_subsys_tb.sv */
// Directed testbench of the CSR subsystem. Checks register access, the mcycle
// counter, PMP permissions and fault capture against a bench-side model.

`include "csr_consts.svh"

module csr_subsys_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 2000;       // watchdog limit for the whole run

    logic               clk;
    logic               resetn;
    csr_req_t           csr_req;
    scan_t              scan;
    logic   [31 : 0]    csr_rd;
    logic               pmp_err;

    logic   [31 : 0]    lfsr;
    int                 mismatches;
    int                 timeouts;
    logic   [31 : 0]    model [logic [11 : 0]];     // writable csrs by address
    logic   [11 : 0]    wr_addrs [$];
    logic   [31 : 0]    sepc_m;
    logic   [31 : 0]    scause_m;

    csr_subsys_top i_csr_subsys_top
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .csr_req_i  ( csr_req   ),
        .csr_rd_o   ( csr_rd    ),
        .scan_i     ( scan      ),
        .pmp_err_o  ( pmp_err   )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30 : 0], fb};
        return fb;
    endfunction

    function automatic logic [31 : 0] rand_word();
        logic [31 : 0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30 : 0], lfsr_bit()};
        return w;
    endfunction

    function automatic logic [31 : 0] resolve(csr_cmd_e cmd, logic [31 : 0] old,
                                              logic [31 : 0] wd);
        case (cmd)
            CSR_SET : return old | wd;
            CSR_CLR : return old & ~wd;
            default : return wd;
        endcase
    endfunction

    function automatic logic [31 : 0] cause_of(access_e kind);
        case (kind)
            ACC_EXEC  : return `CAUSE_INSTR_FAULT;
            ACC_WRITE : return `CAUSE_STORE_FAULT;
            default   : return `CAUSE_LOAD_FAULT;
        endcase
    endfunction

    task automatic check_word(string name, logic [31 : 0] exp, logic [31 : 0] act);
        if (act !== exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_err(string name, logic exp, logic act);
        if (act !== exp)
        begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic init_model();
        wr_addrs = '{`USTATUS_A, `UIE_A, `UTVEC_A, `MSCRATCH_A};
        for (int i = 0; i < `PMP_CFG_WORDS; i++)
            wr_addrs.push_back(12'(`PMPCFG0_A + i));
        for (int i = 0; i < `PMP_ENTRIES; i++)
            wr_addrs.push_back(12'(`PMPADDR0_A + i));
        foreach (wr_addrs[i])
            model[wr_addrs[i]] = '0;
        sepc_m   = '0;
        scause_m = '0;
    endtask

    // one write request, taken at the next rising edge
    task automatic drive_write(logic [11 : 0] addr, csr_cmd_e cmd, logic [31 : 0] wd);
        @(negedge clk);
        scan         = '0;
        csr_req.addr = addr;
        csr_req.wd   = wd;
        csr_req.cmd  = cmd;
        csr_req.wreq = 1'b1;
    endtask

    task automatic read_check(string name, logic [11 : 0] addr, logic [31 : 0] exp);
        @(negedge clk);
        scan         = '0;
        csr_req      = '0;
        csr_req.addr = addr;
        #1;                                     // comb read settles
        check_word(name, exp, csr_rd);
    endtask

    task automatic csr_update(logic [11 : 0] addr, csr_cmd_e cmd, logic [31 : 0] wd);
        model[addr] = resolve(cmd, model[addr], wd);
        drive_write(addr, cmd, wd);
        read_check($sformatf("csr_rd_o @%h", addr), addr, model[addr]);
    endtask

    // one scan access, then sepc and scause read back
    task automatic scan_check(logic valid, access_e kind, logic [31 : 0] addr,
                              logic exp_fault);
        @(negedge clk);
        csr_req    = '0;
        scan.valid = valid;
        scan.kind  = kind;
        scan.addr  = addr;
        #1;
        check_err($sformatf("pmp_err_o @%h", addr), exp_fault, pmp_err);
        if (exp_fault)
        begin
            sepc_m   = addr;
            scause_m = cause_of(kind);
        end
        read_check("sepc", `SEPC_A, sepc_m);
        read_check("scause", `SCAUSE_A, scause_m);
    endtask

    task automatic reset_values();
        foreach (wr_addrs[i])
            read_check($sformatf("csr_rd_o @%h", wr_addrs[i]), wr_addrs[i], 32'h0);
        read_check("sepc", `SEPC_A, 32'h0);
        read_check("scause", `SCAUSE_A, 32'h0);
        read_check("misa", `MISA_A, `MISA_V);
        drive_write(`MISA_A, CSR_WR, rand_word());  // read only
        read_check("misa", `MISA_A, `MISA_V);
        read_check("unmapped", 12'h7c0, 32'h0);
    endtask

    task automatic write_set_clear();
        foreach (wr_addrs[i])
        begin
            csr_update(wr_addrs[i], CSR_WR, rand_word());
            csr_update(wr_addrs[i], CSR_SET, rand_word());
            csr_update(wr_addrs[i], CSR_CLR, rand_word());
        end
    endtask

    task automatic mcycle_counting();
        logic [31 : 0] w;
        logic [31 : 0] bit_mask;
        w        = rand_word();
        bit_mask = 32'h0001_0000;
        drive_write(`MCYCLE_A, CSR_WR, w);
        for (int k = 0; k < 3; k++)
            read_check("mcycle", `MCYCLE_A, w + 32'(k));
        drive_write(`MCYCLE_A, CSR_SET, bit_mask);
        #1;
        check_word("mcycle", w + 32'd3, csr_rd);   // value seen by the set
        read_check("mcycle", `MCYCLE_A, (w + 32'd3) | bit_mask);
    endtask

    task automatic pmp_faults();
        // entry 0 R to 0x1000, entry 1 RWX to 0x2000, entry 2 W only to 0x3000
        csr_update(`PMPCFG0_A, CSR_WR, 32'h000a_0f09);
        csr_update(12'(`PMPCFG0_A + 1), CSR_WR, 32'h0);
        csr_update(12'(`PMPCFG0_A + 2), CSR_WR, 32'h0);
        csr_update(12'(`PMPCFG0_A + 3), CSR_WR, 32'h0);
        csr_update(`PMPADDR0_A, CSR_WR, 32'h0000_0400);
        csr_update(12'(`PMPADDR0_A + 1), CSR_WR, 32'h0000_0800);
        csr_update(12'(`PMPADDR0_A + 2), CSR_WR, 32'h0000_0c00);
        scan_check(1'b1, ACC_READ, 32'h0000_0800, 1'b0);
        scan_check(1'b1, ACC_WRITE, 32'h0000_0800, 1'b1);
        scan_check(1'b1, ACC_EXEC, 32'h0000_1800, 1'b0);
        scan_check(1'b0, ACC_READ, 32'h0000_2800, 1'b0);   // idle, no capture
        scan_check(1'b1, ACC_READ, 32'h0000_2800, 1'b1);
        scan_check(1'b1, ACC_EXEC, 32'h0000_2800, 1'b1);
        scan_check(1'b1, ACC_WRITE, 32'h0000_2800, 1'b0);
        scan_check(1'b1, ACC_READ, 32'h0000_3000, 1'b0);   // above every region
        scan_check(1'b1, ACC_WRITE, 32'h0000_3000, 1'b0);
        scan_check(1'b1, ACC_EXEC, 32'h0000_3000, 1'b0);
    endtask

    task automatic report_result();
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
    endtask

    initial
    begin
        lfsr       = 32'hf298_4f30;
        mismatches = 0;
        timeouts   = 0;
        resetn     = 1'b0;
        csr_req    = '0;
        scan       = '0;
        init_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        reset_values();
        write_set_clear();
        mcycle_counting();
        pmp_faults();
        @(negedge clk);
        report_result();
        $finish;
    end

    // watchdog over the whole run
    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        timeouts++;
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        report_result();
        $finish;
    end

endmodule : csr_subsys_tb

/* build.f */
+incdir+hw
hw/csr_pkg.sv
hw/csr_unit.sv
hw/pmp_unit.sv
hw/csr_subsys_top.sv
bench/csr_subsys_tb.sv

/* hw/csr_consts.svh */
// Shared constants of the CSR subsystem: CSR addresses, misa value, PMP sizing
// and trap cause codes. Include wherever one of these is needed.

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// user-level registers
`define USTATUS_A       12'h000     // user status
`define UIE_A           12'h004     // user interrupt enable
`define UTVEC_A         12'h005     // user trap vector base

// supervisor trap registers, loaded by PMP faults
`define SEPC_A          12'h141     // faulting address
`define SCAUSE_A        12'h142     // fault cause

// machine-level registers
`define MISA_A          12'h301     // read only
`define MSCRATCH_A      12'h340
`define MCYCLE_A        12'hb00     // free-running, writable

// pmp blocks are contiguous from these bases
`define PMPCFG0_A       12'h3a0     // pmpcfg0..pmpcfg3
`define PMPADDR0_A      12'h3b0     // pmpaddr0..pmpaddr15

// RV32I, MXL = 1
`define MISA_V          32'h4000_0100

// pmp sizing
`define PMP_ENTRIES     16
`define PMP_CFG_WORDS   4           // four entries per cfg word

// cause codes written into scause
`define CAUSE_INSTR_FAULT   32'd1
`define CAUSE_LOAD_FAULT    32'd5
`define CAUSE_STORE_FAULT   32'd7

`endif

/* hw/csr_pkg.sv */
// Types shared by the CSR unit, the PMP unit and the subsystem top.
// Modules import this package in their header.

package csr_pkg;

    // csr command from the core
    typedef enum logic [1:0]
    {
        CSR_NONE = 2'b00,
        CSR_WR   = 2'b01,
        CSR_SET  = 2'b10,
        CSR_CLR  = 2'b11
    } csr_cmd_e;

    // kind of the checked memory access
    typedef enum logic [1:0]
    {
        ACC_READ  = 2'b00,
        ACC_WRITE = 2'b01,
        ACC_EXEC  = 2'b10
    } access_e;

    // core request, 47 bits
    typedef struct packed
    {
        logic     [11 : 0]  addr;       // csr address
        logic     [31 : 0]  wd;         // raw write data
        csr_cmd_e           cmd;        // write, set or clear
        logic               wreq;       // write strobe
    } csr_req_t;

    // csr unit to pmp unit, data already resolved
    typedef struct packed
    {
        logic               we;         // write enable
        logic               sel_addr;   // 1 = pmpaddr bank, 0 = pmpcfg bank
        logic     [3  : 0]  index;      // register within the bank
        logic     [31 : 0]  wd;         // resolved write data
    } pmp_wr_t;

    // access presented for the permission check
    typedef struct packed
    {
        logic               valid;      // access present this cycle
        access_e            kind;
        logic     [31 : 0]  addr;       // byte address
    } scan_t;

endpackage : csr_pkg

/* hw/csr_subsys_top.sv */
// CSR subsystem: the CSR unit with its PMP unit attached. The core drives
// CSR requests and scan accesses; read data and the fault flag come back.

module csr_subsys_top
    import csr_pkg::*;
(
    input   logic               clk,
    input   logic               resetn,
    // csr access
    input   csr_req_t           csr_req_i,
    output  logic   [31 : 0]    csr_rd_o,
    // access check
    input   scan_t              scan_i,
    output  logic               pmp_err_o
);

    pmp_wr_t            pmp_wr;     // register access into the pmp
    logic   [31 : 0]    pmp_rd;     // pmp register read data
    logic               pmp_err;    // fault of the current scan

    // fault flag goes to the core and to the fault capture
    assign pmp_err_o = pmp_err;

    csr_unit i_csr_unit
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .csr_req_i  ( csr_req_i ),
        .csr_rd_o   ( csr_rd_o  ),
        .pmp_wr_o   ( pmp_wr    ),
        .pmp_rd_i   ( pmp_rd    ),
        .pmp_err_i  ( pmp_err   ),
        .scan_i     ( scan_i    )
    );

    pmp_unit i_pmp_unit
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .pmp_wr_i   ( pmp_wr    ),
        .pmp_rd_o   ( pmp_rd    ),
        .scan_i     ( scan_i    ),
        .pmp_err_o  ( pmp_err   )
    );

endmodule : csr_subsys_top

/* hw/csr_unit.sv */
// CSR register file of the core. Decodes the request address, resolves
// write/set/clear against the current read value and records PMP faults.

`include "csr_consts.svh"

module csr_unit
    import csr_pkg::*;
(
    input   logic               clk,
    input   logic               resetn,
    // core side
    input   csr_req_t           csr_req_i,
    output  logic   [31 : 0]    csr_rd_o,   // combinational read data
    // pmp side
    output  pmp_wr_t            pmp_wr_o,
    input   logic   [31 : 0]    pmp_rd_i,
    input   logic               pmp_err_i,
    input   scan_t              scan_i
);

    logic   [31 : 0]    ustatus;
    logic   [31 : 0]    uie;
    logic   [31 : 0]    utvec;
    logic   [31 : 0]    mscratch;
    logic   [31 : 0]    mcycle;
    logic   [31 : 0]    sepc;
    logic   [31 : 0]    scause;
    logic   [31 : 0]    rd_data;    // read mux output
    logic   [31 : 0]    wd_eff;     // command-resolved write data
    logic   [31 : 0]    fault_cause;
    logic   [11 : 0]    cfg_off;
    logic   [11 : 0]    addr_off;
    logic               cfg_hit;
    logic               addr_hit;

    // pmp block decode, offsets relative to each bank base
    assign cfg_off  = csr_req_i.addr - `PMPCFG0_A;
    assign addr_off = csr_req_i.addr - `PMPADDR0_A;
    assign cfg_hit  = cfg_off < 12'(`PMP_CFG_WORDS);
    assign addr_hit = addr_off < 12'(`PMP_ENTRIES);

    assign pmp_wr_o.we       = csr_req_i.wreq & (cfg_hit | addr_hit);
    assign pmp_wr_o.sel_addr = addr_hit;
    assign pmp_wr_o.index    = addr_hit ? addr_off[3 : 0] : cfg_off[3 : 0];
    assign pmp_wr_o.wd       = wd_eff;

    // read mux
    always_comb
    begin
        rd_data = '0;                       // unmapped reads as zero
        case (csr_req_i.addr)
            `USTATUS_A  : rd_data = ustatus;
            `UIE_A      : rd_data = uie;
            `UTVEC_A    : rd_data = utvec;
            `SEPC_A     : rd_data = sepc;
            `SCAUSE_A   : rd_data = scause;
            `MISA_A     : rd_data = `MISA_V;
            `MSCRATCH_A : rd_data = mscratch;
            `MCYCLE_A   : rd_data = mcycle;
            default     :
            begin
                if (cfg_hit || addr_hit)
                    rd_data = pmp_rd_i;
            end
        endcase
    end

    assign csr_rd_o = rd_data;

    // set and clear modify the current read value
    always_comb
    begin
        case (csr_req_i.cmd)
            CSR_SET : wd_eff = csr_req_i.wd | rd_data;
            CSR_CLR : wd_eff = ~csr_req_i.wd & rd_data;
            default : wd_eff = csr_req_i.wd;    // none and write
        endcase
    end

    // writable user and machine registers
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ustatus  <= '0;
            uie      <= '0;
            utvec    <= '0;
            mscratch <= '0;
        end
        else if (csr_req_i.wreq)
        begin
            case (csr_req_i.addr)
                `USTATUS_A  : ustatus  <= wd_eff;
                `UIE_A      : uie      <= wd_eff;
                `UTVEC_A    : utvec    <= wd_eff;
                `MSCRATCH_A : mscratch <= wd_eff;
                default     : ;                 // read-only or unmapped
            endcase
        end
    end

    // cycle counter, a write replaces the increment
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mcycle <= '0;
        else if (csr_req_i.wreq && (csr_req_i.addr == `MCYCLE_A))
            mcycle <= wd_eff;
        else
            mcycle <= mcycle + 32'd1;
    end

    // cause code from the access kind
    always_comb
    begin
        case (scan_i.kind)
            ACC_EXEC  : fault_cause = `CAUSE_INSTR_FAULT;
            ACC_WRITE : fault_cause = `CAUSE_STORE_FAULT;
            default   : fault_cause = `CAUSE_LOAD_FAULT;
        endcase
    end

    // fault capture
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sepc   <= '0;
            scause <= '0;
        end
        else if (pmp_err_i)
        begin
            sepc   <= scan_i.addr;
            scause <= fault_cause;
        end
    end

    a_cmd_known : assert property (
        @(posedge clk) disable iff (!resetn)
        csr_req_i.wreq |-> !$isunknown(csr_req_i.cmd)
    );

    // scause only moves on the edge after a pmp fault
    a_scause_on_fault : assert property (
        @(posedge clk) disable iff (!resetn)
        !$stable(scause) |-> $past(pmp_err_i)
    );

endmodule : csr_unit

/* hw/pmp_unit.sv */
// Physical memory protection with 16 TOR-only entries. Registers are indexed
// by the CSR unit through pmp_wr_i; one scan access is checked per cycle.

`include "csr_consts.svh"

module pmp_unit
    import csr_pkg::*;
(
    input   logic               clk,
    input   logic               resetn,
    // register access from the csr unit
    input   pmp_wr_t            pmp_wr_i,
    output  logic   [31 : 0]    pmp_rd_o,
    // access check
    input   scan_t              scan_i,
    output  logic               pmp_err_o
);

    localparam logic [1 : 0] A_TOR = 2'b01;    // other A values mean off

    logic   [`PMP_CFG_WORDS-1 : 0][31 : 0]  pmp_cfg;
    logic   [`PMP_ENTRIES-1   : 0][31 : 0]  pmp_addr;
    logic   [`PMP_ENTRIES-1   : 0][7  : 0]  cfg_byte;  // per-entry view of pmp_cfg
    logic   [`PMP_ENTRIES-1   : 0]          match;
    logic   [33 : 0]                        scan_ext;  // byte address, pmpaddr scale
    logic   [7  : 0]                        win_cfg;   // config of winning entry
    logic                                   any_hit;
    logic                                   allowed;

    // register writes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            pmp_cfg  <= '0;
            pmp_addr <= '0;
        end
        else if (pmp_wr_i.we)
        begin
            if (pmp_wr_i.sel_addr)
                pmp_addr[pmp_wr_i.index] <= pmp_wr_i.wd;
            else
                pmp_cfg[pmp_wr_i.index[1 : 0]] <= pmp_wr_i.wd;
        end
    end

    // register read, bank chosen by the csr unit
    always_comb
    begin
        if (pmp_wr_i.sel_addr)
            pmp_rd_o = pmp_addr[pmp_wr_i.index];
        else
            pmp_rd_o = pmp_cfg[pmp_wr_i.index[1 : 0]];
    end

    assign cfg_byte = pmp_cfg;                  // byte i is entry i
    assign scan_ext = {2'b00, scan_i.addr};

    // TOR range check per entry
    for (genvar g = 0; g < `PMP_ENTRIES; g++)
    begin : g_entry
        logic [33 : 0] lo_bound;
        logic [33 : 0] hi_bound;

        if (g == 0)
        begin : g_first
            assign lo_bound = '0;               // entry 0 starts at zero
        end
        else
        begin : g_rest
            assign lo_bound = {pmp_addr[g-1], 2'b00};
        end

        assign hi_bound = {pmp_addr[g], 2'b00};
        assign match[g] = (cfg_byte[g][4 : 3] == A_TOR) &&
                          (scan_ext >= lo_bound) &&
                          (scan_ext < hi_bound);
    end

    // lowest matching entry wins
    always_comb
    begin
        any_hit = 1'b0;
        win_cfg = '0;
        for (int i = `PMP_ENTRIES - 1; i >= 0; i--)
        begin
            if (match[i])
            begin
                any_hit = 1'b1;
                win_cfg = cfg_byte[i];
            end
        end
    end

    // permission bit for the access kind
    always_comb
    begin
        case (scan_i.kind)
            ACC_READ  : allowed = win_cfg[0];
            ACC_WRITE : allowed = win_cfg[1];
            ACC_EXEC  : allowed = win_cfg[2];
            default   : allowed = 1'b0;
        endcase
    end

    // no matching entry means no fault
    assign pmp_err_o = scan_i.valid & any_hit & ~allowed;

    // a cfg write beyond the last word would alias onto a lower word
    a_cfg_index_range : assert property (
        @(posedge clk) disable iff (!resetn)
        (pmp_wr_i.we && !pmp_wr_i.sel_addr) |-> (pmp_wr_i.index < 4'(`PMP_CFG_WORDS))
    );

endmodule : pmp_unit

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CSR subsystem testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=csr_subsys_sim

verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module csr_subsys_tb \
    -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"
if [ $SIM_STATUS -ne 0 ]; then
    echo "simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "failure reported, see $LOG"
    exit 1
fi

echo "no failure found in $LOG"
exit 0
